// File: source/warpIssuePkg.sv
package warpIssuePkg;

    // Register, scoreboard entry and data widths
    typedef logic [4:0]  regId_t;
    typedef logic [1:0]  scbId_t;
    typedef logic [15:0] data_t;

    // Entry count, tied to the scbId_t width
    localparam int SCB_ENTRIES = 4;

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opXor,
        opLoad,
        opStore
    } opcode_t;

    // Loads and stores take the memory path
    function automatic logic isMemOp(opcode_t op);
        return (op == opLoad) || (op == opStore);
    endfunction

    // ALU result for one opcode, memory ops give zero
    function automatic data_t aluCompute(opcode_t op, data_t a, data_t b);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opXor:   return a ^ b;
            default: return '0;
        endcase
    endfunction

endpackage

// File: source/warpScoreboard.sv
`timescale 1ns/1ps

module warpScoreboard
    import warpIssuePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    // Instruction presented by the issue stage
    input  regId_t src1,
    input  regId_t src2,
    input  regId_t dst,
    input  logic   src1Valid,
    input  logic   src2Valid,
    input  logic   dstValid,
    // Allocate entry freeId
    input  logic   grant,
    // Retire requests from the completion merger
    input  logic   clearAlu,
    input  scbId_t clearAluId,
    input  logic   clearMem,
    input  scbId_t clearMemId,
    output logic   full,
    output logic   empty,
    output logic   depend,
    output scbId_t freeId
);

    // Per-entry register IDs of the instruction in flight
    regId_t src1Tab [SCB_ENTRIES];
    regId_t src2Tab [SCB_ENTRIES];
    regId_t dstTab  [SCB_ENTRIES];
    logic [SCB_ENTRIES-1:0] src1ValidTab;
    logic [SCB_ENTRIES-1:0] src2ValidTab;
    logic [SCB_ENTRIES-1:0] dstValidTab;

    // Occupancy, before and after this cycle's clears
    logic [SCB_ENTRIES-1:0] valid;
    logic [SCB_ENTRIES-1:0] validCleared;

    // Hazard kinds per entry
    logic [SCB_ENTRIES-1:0] raw;
    logic [SCB_ENTRIES-1:0] waw;
    logic [SCB_ENTRIES-1:0] war;

    //////////////////////////////
    // Occupancy
    //////////////////////////////

    // Both clears apply before any decision this cycle
    always_comb begin
        validCleared = valid;
        if (clearAlu) begin
            validCleared[clearAluId] = 1'b0;
        end
        if (clearMem) begin
            validCleared[clearMemId] = 1'b0;
        end
    end

    assign full  = &validCleared;
    assign empty = ~|validCleared;

    // Lowest free index, scanned from the top down
    always_comb begin
        freeId = '0;
        for (int i = SCB_ENTRIES - 1; i >= 0; i--) begin
            if (!validCleared[i]) begin
                freeId = scbId_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
        end else begin
            valid <= validCleared;
            if (grant) begin
                valid[freeId] <= 1'b1;
            end
        end
    end

    // Entry contents, only meaningful while valid
    always_ff @(posedge clk) begin
        if (grant) begin
            src1Tab[freeId]      <= src1;
            src2Tab[freeId]      <= src2;
            dstTab[freeId]       <= dst;
            src1ValidTab[freeId] <= src1Valid;
            src2ValidTab[freeId] <= src2Valid;
            dstValidTab[freeId]  <= dstValid;
        end
    end

    //////////////////////////////
    // Hazard check
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < SCB_ENTRIES; i++) begin
            // New source reads a pending destination
            raw[i] = dstValidTab[i] &&
                     ((src1Valid && (src1 == dstTab[i])) ||
                      (src2Valid && (src2 == dstTab[i])));
            // Two writes to one register
            waw[i] = dstValid && dstValidTab[i] && (dst == dstTab[i]);
            // New destination overwrites a pending source
            war[i] = dstValid &&
                     ((src1ValidTab[i] && (dst == src1Tab[i])) ||
                      (src2ValidTab[i] && (dst == src2Tab[i])));
        end
    end

    // Entries freed this cycle no longer block
    assign depend = |((raw | waw | war) & validCleared);

endmodule

// File: source/warpIssueStage.sv
`timescale 1ns/1ps

module warpIssueStage
    import warpIssuePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    // Four-phase instruction handshake
    input  logic    instrReq,
    output logic    instrAck,
    input  opcode_t instrOp,
    input  regId_t  instrSrc1,
    input  regId_t  instrSrc2,
    input  regId_t  instrDst,
    input  logic    instrSrc1Valid,
    input  logic    instrSrc2Valid,
    input  logic    instrDstValid,
    input  data_t   instrOpA,
    input  data_t   instrOpB,
    input  data_t   instrAddr,
    // Scoreboard and path status
    input  logic    depend,
    input  logic    full,
    input  scbId_t  freeId,
    input  logic    memBusy,
    output logic    scbGrant,
    // Dispatch
    output logic    aluStart,
    output logic    memStart,
    output opcode_t startOp,
    output data_t   startA,
    output data_t   startB,
    output regId_t  startDst,
    output scbId_t  startScbId
);

    typedef enum logic [1:0] {sIdle, sWait, sAcked} state_t;

    state_t state;
    logic   memOp;
    logic   canDispatch;
    data_t  operandA;
    data_t  operandB;

    assign memOp = isMemOp(instrOp);

    // Absent source or register 0 reads as zero
    assign operandA = (instrSrc1Valid && (instrSrc1 != '0)) ? instrOpA : '0;
    assign operandB = (instrSrc2Valid && (instrSrc2 != '0)) ? instrOpB : '0;

    // Held fields are stable while instrReq is high
    assign canDispatch = (state == sWait) && !depend && !full && !(memOp && memBusy);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= sIdle;
        end else begin
            case (state)
                sIdle:   if (instrReq) state <= sWait;
                sWait:   if (canDispatch) state <= sAcked;
                sAcked:  if (!instrReq) state <= sIdle;
                default: state <= sIdle;
            endcase
        end
    end

    // Ack one cycle after dispatch, held until req falls
    assign instrAck = (state == sAcked);

    //////////////////////////////
    // Dispatch
    //////////////////////////////

    assign scbGrant   = canDispatch;
    assign aluStart   = canDispatch && !memOp;
    assign memStart   = canDispatch && memOp;
    assign startOp    = instrOp;
    // Memory ops carry address in A and store data in B
    assign startA     = memOp ? instrAddr : operandA;
    assign startB     = operandB;
    assign startDst   = instrDstValid ? instrDst : '0;
    assign startScbId = freeId;

endmodule

// File: source/aluPipe.sv
`timescale 1ns/1ps

module aluPipe
    import warpIssuePkg::*;
#(
    parameter int ALU_LATENCY = 3
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  opcode_t op,
    input  data_t   opA,
    input  data_t   opB,
    input  regId_t  dst,
    input  scbId_t  scbId,
    output logic    done,
    output regId_t  doneDst,
    output data_t   result,
    output scbId_t  doneScbId
);

    // One operation per stage, result computed on entry
    logic [ALU_LATENCY-1:0] validPipe;
    data_t  resultPipe [ALU_LATENCY];
    regId_t dstPipe    [ALU_LATENCY];
    scbId_t scbIdPipe  [ALU_LATENCY];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= start;
            for (int i = 1; i < ALU_LATENCY; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    // Payload follows the valid bits
    always_ff @(posedge clk) begin
        resultPipe[0] <= aluCompute(op, opA, opB);
        dstPipe[0]    <= dst;
        scbIdPipe[0]  <= scbId;
        for (int i = 1; i < ALU_LATENCY; i++) begin
            resultPipe[i] <= resultPipe[i-1];
            dstPipe[i]    <= dstPipe[i-1];
            scbIdPipe[i]  <= scbIdPipe[i-1];
        end
    end

    // Exactly ALU_LATENCY cycles after start
    assign done      = validPipe[ALU_LATENCY-1];
    assign result    = resultPipe[ALU_LATENCY-1];
    assign doneDst   = dstPipe[ALU_LATENCY-1];
    assign doneScbId = scbIdPipe[ALU_LATENCY-1];

endmodule

// File: source/memAccessUnit.sv
`timescale 1ns/1ps

module memAccessUnit
    import warpIssuePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  opcode_t op,
    input  data_t   addr,
    input  data_t   wdata,
    input  regId_t  dst,
    input  scbId_t  scbId,
    // External four-phase memory handshake
    output logic    memReq,
    output logic    memWrite,
    output data_t   memAddr,
    output data_t   memWdata,
    input  logic    memAck,
    input  data_t   memRdata,
    // Completion toward the merger
    output logic    busy,
    output logic    done,
    output logic    isLoad,
    output regId_t  doneDst,
    output data_t   doneData,
    output scbId_t  doneScbId,
    input  logic    taken
);

    // sPre waits for the previous ack to fall
    typedef enum logic [1:0] {sIdle, sPre, sReq, sDone} state_t;

    state_t state;
    logic   writeReg;
    data_t  addrReg;
    data_t  wdataReg;
    data_t  rdataReg;
    regId_t dstReg;
    scbId_t scbIdReg;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= sIdle;
        end else begin
            case (state)
                sIdle:   if (start) state <= memAck ? sPre : sReq;
                sPre:    if (!memAck) state <= sReq;
                sReq:    if (memAck) state <= sDone;
                sDone:   if (taken) state <= sIdle;
                default: state <= sIdle;
            endcase
        end
    end

    // Access fields held for the whole transfer
    always_ff @(posedge clk) begin
        if (start && (state == sIdle)) begin
            writeReg <= (op == opStore);
            addrReg  <= addr;
            wdataReg <= wdata;
            dstReg   <= dst;
            scbIdReg <= scbId;
        end
        if ((state == sReq) && memAck) begin
            rdataReg <= memRdata;
        end
    end

    assign memReq    = (state == sReq);
    assign memWrite  = writeReg;
    assign memAddr   = addrReg;
    assign memWdata  = wdataReg;

    // Held until the merger takes it
    assign busy      = (state != sIdle);
    assign done      = (state == sDone);
    assign isLoad    = !writeReg;
    assign doneDst   = dstReg;
    assign doneData  = rdataReg;
    assign doneScbId = scbIdReg;

endmodule

// File: source/completionMerge.sv
`timescale 1ns/1ps

module completionMerge
    import warpIssuePkg::*;
(
    // ALU completion, cannot be stalled
    input  logic   aluDone,
    input  regId_t aluDst,
    input  data_t  aluResult,
    input  scbId_t aluScbId,
    // Memory completion, held until taken
    input  logic   memDone,
    input  logic   memIsLoad,
    input  regId_t memDst,
    input  data_t  memData,
    input  scbId_t memScbId,
    output logic   memTaken,
    // Scoreboard clears
    output logic   clearAlu,
    output scbId_t clearAluId,
    output logic   clearMem,
    output scbId_t clearMemId,
    // Single writeback port
    output logic   wbValid,
    output regId_t wbDst,
    output data_t  wbData
);

    // Stores retire at once, loads wait for an idle port
    assign memTaken = memDone && (!memIsLoad || !aluDone);

    assign clearAlu   = aluDone;
    assign clearAluId = aluScbId;
    assign clearMem   = memTaken;
    assign clearMemId = memScbId;

    //////////////////////////////
    // Writeback arbitration
    //////////////////////////////

    // ALU has priority
    assign wbValid = aluDone || (memTaken && memIsLoad);
    assign wbDst   = aluDone ? aluDst : memDst;
    assign wbData  = aluDone ? aluResult : memData;

endmodule

// File: source/warpIssueTop.sv
`timescale 1ns/1ps

module warpIssueTop
    import warpIssuePkg::*;
#(
    parameter int ALU_LATENCY = 3
) (
    input  logic    clk,
    input  logic    rst,
    // Instruction handshake
    input  logic    instrReq,
    output logic    instrAck,
    input  opcode_t instrOp,
    input  regId_t  instrSrc1,
    input  regId_t  instrSrc2,
    input  regId_t  instrDst,
    input  logic    instrSrc1Valid,
    input  logic    instrSrc2Valid,
    input  logic    instrDstValid,
    input  data_t   instrOpA,
    input  data_t   instrOpB,
    input  data_t   instrAddr,
    // Memory handshake
    output logic    memReq,
    output logic    memWrite,
    output data_t   memAddr,
    output data_t   memWdata,
    input  logic    memAck,
    input  data_t   memRdata,
    // Writeback
    output logic    wbValid,
    output regId_t  wbDst,
    output data_t   wbData
);

    // Scoreboard status and clears
    logic    depend;
    logic    full;
    logic    empty;
    scbId_t  freeId;
    logic    scbGrant;
    logic    clearAlu;
    scbId_t  clearAluId;
    logic    clearMem;
    scbId_t  clearMemId;

    // Dispatch bundle
    logic    aluStart;
    logic    memStart;
    opcode_t startOp;
    data_t   startA;
    data_t   startB;
    regId_t  startDst;
    scbId_t  startScbId;

    // Path completions
    logic    aluDone;
    regId_t  aluDst;
    data_t   aluResult;
    scbId_t  aluScbId;
    logic    memBusy;
    logic    memDone;
    logic    memIsLoad;
    regId_t  memDst;
    data_t   memData;
    scbId_t  memScbId;
    logic    memTaken;

    warpIssueStage issueStage (
        .clk            (clk),
        .rst            (rst),
        .instrReq       (instrReq),
        .instrAck       (instrAck),
        .instrOp        (instrOp),
        .instrSrc1      (instrSrc1),
        .instrSrc2      (instrSrc2),
        .instrDst       (instrDst),
        .instrSrc1Valid (instrSrc1Valid),
        .instrSrc2Valid (instrSrc2Valid),
        .instrDstValid  (instrDstValid),
        .instrOpA       (instrOpA),
        .instrOpB       (instrOpB),
        .instrAddr      (instrAddr),
        .depend         (depend),
        .full           (full),
        .freeId         (freeId),
        .memBusy        (memBusy),
        .scbGrant       (scbGrant),
        .aluStart       (aluStart),
        .memStart       (memStart),
        .startOp        (startOp),
        .startA         (startA),
        .startB         (startB),
        .startDst       (startDst),
        .startScbId     (startScbId)
    );

    // Sees the held instruction fields directly
    warpScoreboard scoreboard (
        .clk        (clk),
        .rst        (rst),
        .src1       (instrSrc1),
        .src2       (instrSrc2),
        .dst        (instrDst),
        .src1Valid  (instrSrc1Valid),
        .src2Valid  (instrSrc2Valid),
        .dstValid   (instrDstValid),
        .grant      (scbGrant),
        .clearAlu   (clearAlu),
        .clearAluId (clearAluId),
        .clearMem   (clearMem),
        .clearMemId (clearMemId),
        .full       (full),
        .empty      (empty),
        .depend     (depend),
        .freeId     (freeId)
    );

    aluPipe #(
        .ALU_LATENCY (ALU_LATENCY)
    ) alu (
        .clk       (clk),
        .rst       (rst),
        .start     (aluStart),
        .op        (startOp),
        .opA       (startA),
        .opB       (startB),
        .dst       (startDst),
        .scbId     (startScbId),
        .done      (aluDone),
        .doneDst   (aluDst),
        .result    (aluResult),
        .doneScbId (aluScbId)
    );

    memAccessUnit memUnit (
        .clk       (clk),
        .rst       (rst),
        .start     (memStart),
        .op        (startOp),
        .addr      (startA),
        .wdata     (startB),
        .dst       (startDst),
        .scbId     (startScbId),
        .memReq    (memReq),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memAck    (memAck),
        .memRdata  (memRdata),
        .busy      (memBusy),
        .done      (memDone),
        .isLoad    (memIsLoad),
        .doneDst   (memDst),
        .doneData  (memData),
        .doneScbId (memScbId),
        .taken     (memTaken)
    );

    completionMerge merge (
        .aluDone    (aluDone),
        .aluDst     (aluDst),
        .aluResult  (aluResult),
        .aluScbId   (aluScbId),
        .memDone    (memDone),
        .memIsLoad  (memIsLoad),
        .memDst     (memDst),
        .memData    (memData),
        .memScbId   (memScbId),
        .memTaken   (memTaken),
        .clearAlu   (clearAlu),
        .clearAluId (clearAluId),
        .clearMem   (clearMem),
        .clearMemId (clearMemId),
        .wbValid    (wbValid),
        .wbDst      (wbDst),
        .wbData     (wbData)
    );

endmodule

// File: tb/warpScoreboard_assertions.sv
`timescale 1ns/1ps

module warpScoreboardAssertions (
    input logic clk,
    input logic rst,
    input logic full,
    input logic empty,
    input logic grant,
    input logic depend
);

    //////////////////////////////
    // Scoreboard invariants
    //////////////////////////////

    // Occupancy only grows through an allocation
    growsOnGrant: assert property (@(posedge clk) disable iff (!rst)
        ($rose(full) || $fell(empty)) |-> $past(grant))
        else $error("Scoreboard occupancy grew without a grant");

    // No allocation without a free entry
    noGrantWhenFull: assert property (@(posedge clk) disable iff (!rst) !(grant && full))
        else $error("Scoreboard granted while full");

    // No allocation past a hazard
    noGrantOnHazard: assert property (@(posedge clk) disable iff (!rst) !(grant && depend))
        else $error("Scoreboard granted while a hazard was flagged");

endmodule

// File: tb/warpIssueTb.sv
`timescale 1ns/1ps

module warpIssueTb;
    import warpIssuePkg::*;

    localparam int ALU_LATENCY    = 3;
    localparam int RANDOM_COUNT   = 200;
    // About 20 cycles per random instruction, slow memory and stalls included
    localparam int TIMEOUT_CYCLES = 20 * RANDOM_COUNT;

    logic    clk;
    logic    rst;
    logic    instrReq;
    logic    instrAck;
    opcode_t instrOp;
    regId_t  instrSrc1;
    regId_t  instrSrc2;
    regId_t  instrDst;
    logic    instrSrc1Valid;
    logic    instrSrc2Valid;
    logic    instrDstValid;
    data_t   instrOpA;
    data_t   instrOpB;
    data_t   instrAddr;
    logic    memReq;
    logic    memWrite;
    data_t   memAddr;
    data_t   memWdata;
    logic    memAck;
    data_t   memRdata;
    logic    wbValid;
    regId_t  wbDst;
    data_t   wbData;

    // Architectural state, updated in issue order
    data_t       shadowReg [32];
    data_t       shadowMem [data_t];
    // Contents held by the memory model
    data_t       memArray [data_t];
    // Pending writebacks as {register, value}
    logic [20:0] expQueue [$];

    data_t       lastWb [32];
    int          wbSeq [32];
    int          wbOrder;
    int          errorCount;
    int          checkCount;
    int          cycleCount;
    logic [31:0] stimState;
    logic [31:0] memState;
    int          ackDelayMax;
    logic        holdAck;

    warpIssueTop #(
        .ALU_LATENCY (ALU_LATENCY)
    ) UUT (
        .clk            (clk),
        .rst            (rst),
        .instrReq       (instrReq),
        .instrAck       (instrAck),
        .instrOp        (instrOp),
        .instrSrc1      (instrSrc1),
        .instrSrc2      (instrSrc2),
        .instrDst       (instrDst),
        .instrSrc1Valid (instrSrc1Valid),
        .instrSrc2Valid (instrSrc2Valid),
        .instrDstValid  (instrDstValid),
        .instrOpA       (instrOpA),
        .instrOpB       (instrOpB),
        .instrAddr      (instrAddr),
        .memReq         (memReq),
        .memWrite       (memWrite),
        .memAddr        (memAddr),
        .memWdata       (memWdata),
        .memAck         (memAck),
        .memRdata       (memRdata),
        .wbValid        (wbValid),
        .wbDst          (wbDst),
        .wbData         (wbData)
    );

    bind warpScoreboard warpScoreboardAssertions scbChecks (
        .clk    (clk),
        .rst    (rst),
        .full   (full),
        .empty  (empty),
        .grant  (grant),
        .depend (depend)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    //////////////////////////////
    // Models and helpers
    //////////////////////////////

    function automatic logic [31:0] lcgNext(logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int nextStim(int limit);
        stimState = lcgNext(stimState);
        return int'(stimState[30:16]) % limit;
    endfunction

    function automatic data_t aluReference(opcode_t op, data_t a, data_t b);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opXor:   return a ^ b;
            default: return 16'h0000;
        endcase
    endfunction

    // Preset memory contents, every address bit matters
    function automatic data_t presetValue(data_t addr);
        return {addr[7:0], addr[15:8]} ^ 16'hC35A;
    endfunction

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // Drives one instruction and records what it should produce
    task automatic presentInstr(opcode_t op, regId_t src1, logic src1Valid, regId_t src2,
                                logic src2Valid, regId_t dst, data_t addr);
        data_t a;
        data_t b;
        data_t value;
        a = src1Valid ? shadowReg[src1] : 16'h0000;
        b = src2Valid ? shadowReg[src2] : 16'h0000;
        instrOp        = op;
        instrSrc1      = src1;
        instrSrc2      = src2;
        instrDst       = dst;
        instrSrc1Valid = src1Valid;
        instrSrc2Valid = src2Valid;
        instrDstValid  = (op != opStore);
        // Operand values go out unmasked
        instrOpA       = shadowReg[src1];
        instrOpB       = shadowReg[src2];
        instrAddr      = addr;
        instrReq       = 1'b1;
        if (op == opStore) begin
            shadowMem[addr] = b;
        end else begin
            if (op == opLoad) begin
                value = shadowMem.exists(addr) ? shadowMem[addr] : presetValue(addr);
            end else begin
                value = aluReference(op, a, b);
            end
            expQueue.push_back({dst, value});
            shadowReg[dst] = value;
        end
    endtask

    // Four-phase completion, sampled 1 ns after each edge
    task automatic finishHandshake();
        while (instrAck !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        instrReq = 1'b0;
        while (instrAck !== 1'b0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issueInstr(opcode_t op, regId_t src1, logic src1Valid, regId_t src2,
                              logic src2Valid, regId_t dst, data_t addr);
        presentInstr(op, src1, src1Valid, src2, src2Valid, dst, addr);
        finishHandshake();
    endtask

    task automatic drainWritebacks();
        while ((expQueue.size() != 0) || memReq || memAck) begin
            @(posedge clk);
            #1;
        end
        repeat (2) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic reportTest(string name, int errorsBefore);
        $display("Test %s: %s", name, (errorCount == errorsBefore) ? "ok" : "mismatches");
    endtask

    // Load to r3 held in memory, then one dependent instruction
    task automatic hazardCase(opcode_t depOp, regId_t depSrc1, regId_t depDst, data_t addr);
        int orderBefore;
        holdAck = 1'b1;
        issueInstr(opLoad, 5'd5, 1'b1, 5'd0, 1'b0, 5'd3, addr);
        presentInstr(depOp, depSrc1, 1'b1, 5'd2, 1'b1, depDst, 16'h0000);
        repeat (12) begin
            @(posedge clk);
            #1;
            checkValue("instrAck", instrAck, 0);
        end
        checkValue("memReq", memReq, 1);
        orderBefore = wbOrder;
        holdAck = 1'b0;
        finishHandshake();
        drainWritebacks();
        // Dependent result is the later of the two
        checkValue("dependent wb order", wbSeq[depDst], orderBefore + 2);
    endtask

    //////////////////////////////
    // Memory model
    //////////////////////////////

    initial begin : memoryModel
        int waitCount;
        int delay;
        memAck    = 1'b0;
        memRdata  = 16'h0000;
        waitCount = 0;
        delay     = 0;
        forever begin
            @(posedge clk);
            #1;
            if (memReq && !memAck) begin
                if (holdAck) begin
                    waitCount = 0;
                end else if (waitCount >= delay) begin
                    if (memWrite) begin
                        memArray[memAddr] = memWdata;
                    end else begin
                        memRdata = memArray.exists(memAddr) ? memArray[memAddr]
                                                            : presetValue(memAddr);
                    end
                    memAck    = 1'b1;
                    waitCount = 0;
                    memState  = lcgNext(memState);
                    delay     = int'(memState[31:16]) % (ackDelayMax + 1);
                end else begin
                    waitCount++;
                end
            end else if (!memReq && memAck) begin
                memAck = 1'b0;
            end
        end
    end

    //////////////////////////////
    // Writeback checker
    //////////////////////////////

    initial begin : writebackChecker
        int idx;
        forever begin
            @(negedge clk);
            if (rst && wbValid) begin
                idx = -1;
                // Oldest pending value for this register
                for (int i = 0; i < expQueue.size(); i++) begin
                    if ((idx < 0) && (expQueue[i][20:16] == wbDst)) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    errorCount++;
                    $display("Unexpected writeback to r%0d with 0x%0h at %0t",
                             wbDst, wbData, $time);
                end else begin
                    checkValue($sformatf("wbData r%0d", wbDst), wbData, expQueue[idx][15:0]);
                    expQueue.delete(idx);
                end
                wbOrder++;
                lastWb[wbDst] = wbData;
                wbSeq[wbDst]  = wbOrder;
            end
        end
    end

    initial begin : cycleLimit
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        int      errorsBefore;
        opcode_t op;
        regId_t  src1;
        regId_t  src2;
        regId_t  dst;
        logic    src1Valid;
        logic    src2Valid;
        data_t   addr;
        rst            = 1'b0;
        instrReq       = 1'b0;
        instrOp        = opAdd;
        instrSrc1      = '0;
        instrSrc2      = '0;
        instrDst       = '0;
        instrSrc1Valid = 1'b0;
        instrSrc2Valid = 1'b0;
        instrDstValid  = 1'b0;
        instrOpA       = '0;
        instrOpB       = '0;
        instrAddr      = '0;
        stimState      = 32'd94088;
        memState       = lcgNext(32'd94088);
        ackDelayMax    = 0;
        holdAck        = 1'b0;
        errorCount     = 0;
        checkCount     = 0;
        wbOrder        = 0;
        for (int r = 0; r < 32; r++) begin
            shadowReg[r] = (r == 0) ? 16'h0000 : 16'h1000 + 16'(r) * 16'h0123;
            lastWb[r]    = 16'h0000;
            wbSeq[r]     = 0;
        end

        // Reset for 10 cycles
        repeat (10) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b1;

        errorsBefore = errorCount;
        repeat (5) begin
            checkValue("instrAck", instrAck, 0);
            checkValue("memReq", memReq, 0);
            checkValue("wbValid", wbValid, 0);
            @(posedge clk);
            #1;
        end
        reportTest("1 reset state", errorsBefore);

        // Independent ALU ops, r10 to r15
        errorsBefore = errorCount;
        for (int i = 0; i < 6; i++) begin
            issueInstr(opcode_t'(i % 4), regId_t'(1 + i), 1'b1, regId_t'(2 + i), 1'b1,
                       regId_t'(10 + i), 16'h0000);
        end
        drainWritebacks();
        for (int i = 10; i < 15; i++) begin
            checkValue($sformatf("wb order r%0d", i + 1), wbSeq[i + 1] - wbSeq[i], 1);
        end
        reportTest("2 independent ALU ops", errorsBefore);

        // Store then load, and a never-written address
        errorsBefore = errorCount;
        ackDelayMax  = 2;
        issueInstr(opStore, 5'd0, 1'b0, 5'd1, 1'b1, 5'd0, 16'h0200);
        issueInstr(opLoad, 5'd0, 1'b0, 5'd0, 1'b0, 5'd20, 16'h0200);
        issueInstr(opLoad, 5'd0, 1'b0, 5'd0, 1'b0, 5'd21, 16'h0333);
        drainWritebacks();
        checkValue("r20", lastWb[20], 16'h1000 + 16'h0123);
        checkValue("r21", lastWb[21], presetValue(16'h0333));
        reportTest("3 store and load", errorsBefore);

        // RAW, WAW and WAR behind a stalled load
        errorsBefore = errorCount;
        ackDelayMax  = 0;
        hazardCase(opAdd, 5'd3, 5'd6, 16'h0300);
        hazardCase(opSub, 5'd1, 5'd3, 16'h0301);
        hazardCase(opXor, 5'd1, 5'd5, 16'h0302);
        reportTest("4 hazard ordering", errorsBefore);

        // Random mix with slow memory
        errorsBefore = errorCount;
        ackDelayMax  = 6;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            op        = opcode_t'(nextStim(6));
            src1      = regId_t'(nextStim(16));
            src2      = regId_t'(nextStim(16));
            dst       = regId_t'(nextStim(15) + 1);
            src1Valid = (nextStim(4) != 0);
            src2Valid = (nextStim(4) != 0);
            addr      = 16'h0400 + 16'(nextStim(16));
            presentInstr(op, src1, src1Valid, src2, src2Valid, dst, addr);
            finishHandshake();
        end
        drainWritebacks();
        for (int r = 1; r < 32; r++) begin
            if (wbSeq[r] != 0) begin
                checkValue($sformatf("final r%0d", r), lastWb[r], shadowReg[r]);
            end
        end
        reportTest("5 random mix", errorsBefore);

        $display("Summary: 5 tests, %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: warpIssueTop.f
source/warpIssuePkg.sv
source/warpScoreboard.sv
source/warpIssueStage.sv
source/aluPipe.sv
source/memAccessUnit.sv
source/completionMerge.sv
source/warpIssueTop.sv
tb/warpScoreboard_assertions.sv
tb/warpIssueTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = warpIssueTb
FILELIST  = warpIssueTop.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
